// File: src/cache_req_pkg.sv
// Shared widths and packet types for two requestors and read-only cache requests with 32-bit addresses

package cache_req_pkg;

  // ----------------------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------------------

  // Requestor ports feeding the arbiter
  localparam int num_requestors = 2;

  // Base, offset and cache address width
  localparam int addr_w = 32;

  // Tag wide enough for every requestor number
  localparam int req_id_w = 1;

  // Request queue entries
  localparam int fifo_depth = 16;

  // Requests the cache may hold before completing them
  localparam int outstanding_max = 4;

  // Counts 0 through outstanding_max
  localparam int credit_w = 3;

  // ----------------------------------------------------------------------
  // Packet types
  // ----------------------------------------------------------------------

  // Requestor packet
  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] base_address;
    logic [addr_w-1:0] address_offset;
  } mem_request_t;

  // Read request toward the cache
  // Address already resolved as base plus offset
  typedef struct packed {
    logic                valid;
    logic [req_id_w-1:0] req_id;
    logic [addr_w-1:0]   addr;
  } cache_request_t;

  // Request queue flags
  // Also exported at the top level for monitoring
  typedef struct packed {
    logic empty;
    logic full;
    logic almost_full;
  } fifo_status_t;

endpackage : cache_req_pkg

// File: src/request_arbiter.sv
// Fixed at two requestors and a port takes at most one packet every other cycle since ready drops while its slot waits
`timescale 1ns/10ps

module request_arbiter (
  input  logic                                     ap_clk                                    ,
  input  logic                                     control_areset                            ,
  input  cache_req_pkg::mem_request_t              mem_req_in [cache_req_pkg::num_requestors],
  output logic [cache_req_pkg::num_requestors-1:0] mem_req_ready                             ,
  input  logic                                     fifo_almost_full                          ,
  output cache_req_pkg::cache_request_t            fifo_wr
);
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Holding slots
  // ----------------------------------------------------------------------
  mem_request_t              slot [num_requestors];
  logic [num_requestors-1:0] slot_full;
  logic [num_requestors-1:0] accept;
  logic [num_requestors-1:0] granted;

  // Grant selection
  logic                grant_en;
  logic [req_id_w-1:0] grant_idx;
  logic [req_id_w-1:0] rr_ptr;

  // Slot state and handshake per port
  always_comb begin
    for (int i = 0; i < num_requestors; i++) begin
      slot_full[i] = slot[i].valid;
      accept[i]    = mem_req_in[i].valid & ~slot[i].valid;
      granted[i]   = grant_en & (grant_idx == i);
    end
  end

  // Free slot means ready
  assign mem_req_ready = ~slot_full;

  // Load on accept and empty on grant
  // Both never coincide for one slot
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < num_requestors; i++) begin
      if (control_areset) begin
        slot[i].valid <= 1'b0;
      end else if (accept[i]) begin
        slot[i].valid <= 1'b1;
      end else if (granted[i]) begin
        slot[i].valid <= 1'b0;
      end
      if (accept[i]) begin
        slot[i].base_address   <= mem_req_in[i].base_address;
        slot[i].address_offset <= mem_req_in[i].address_offset;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Round-robin grant
  // ----------------------------------------------------------------------

  // Stall on almost_full so the in-flight write still fits
  always_comb begin
    grant_en = ~fifo_almost_full & (|slot_full);
    if (&slot_full) begin
      grant_idx = rr_ptr;
    end else if (slot_full[1]) begin
      grant_idx = 1'b1;
    end else begin
      grant_idx = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Address formation into the FIFO write register
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      fifo_wr.valid <= 1'b0;
      rr_ptr        <= '0;
    end else begin
      fifo_wr.valid <= grant_en;
      // Pointer only moves on a contested grant
      if (grant_en && (&slot_full)) begin
        rr_ptr <= ~rr_ptr;
      end
    end
    // Tag with the winning slot number
    if (grant_en) begin
      fifo_wr.req_id <= grant_idx;
      fifo_wr.addr   <= slot[grant_idx].base_address + slot[grant_idx].address_offset;
    end
  end

endmodule : request_arbiter

// File: src/request_fifo.sv
// Payload type must carry a valid bit used as write enable and almost_full leaves room for two writes in flight
`timescale 1ns/10ps

module request_fifo #(
  parameter type payload_t = cache_req_pkg::cache_request_t
) (
  input  logic                        ap_clk        ,
  input  logic                        control_areset,
  input  payload_t                    wr_data       ,
  input  logic                        rd_en         ,
  output payload_t                    rd_data       ,
  output cache_req_pkg::fifo_status_t status
);
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------------------
  payload_t                        mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0]   wr_ptr;
  logic [$clog2(fifo_depth)-1:0]   rd_ptr;
  logic [$clog2(fifo_depth+1)-1:0] count;

  // Qualified enables
  logic wr_en;
  logic rd_go;

  // Drop writes when full and reads when empty
  assign wr_en = wr_data.valid & ~status.full;
  assign rd_go = rd_en & ~status.empty;

  // Buffer write
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Read data lands one cycle after rd_en
  always_ff @(posedge ap_clk) begin
    if (rd_go) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // ----------------------------------------------------------------------
  // Pointer and occupancy update
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Circular wrap
      if (wr_en) begin
        wr_ptr <= (wr_ptr == fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_go) begin
        rd_ptr <= (rd_ptr == fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave count alone
      case ({wr_en, rd_go})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flags from occupancy
  // almost_full at two or fewer free entries
  always_comb begin
    status.empty       = (count == 0);
    status.full        = (count == fifo_depth);
    status.almost_full = (count >= fifo_depth - 2);
  end

endmodule : request_fifo

// File: src/credit_counter.sv
// Counts free cache slots starting at outstanding_max and never climbs above it
`timescale 1ns/10ps

module credit_counter (
  input  logic ap_clk        ,
  input  logic control_areset,
  input  logic take          ,
  input  logic give          ,
  output logic no_credit
);
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Free credit register
  // ----------------------------------------------------------------------
  logic [credit_w-1:0] credits;

  // Full credit after reset
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      credits <= outstanding_max[credit_w-1:0];
    end else begin
      case ({take, give})
        // Request accepted by the cache
        2'b10: begin
          if (credits != '0) begin
            credits <= credits - 1'b1;
          end
        end
        // Completion returned
        2'b01: begin
          if (credits != outstanding_max[credit_w-1:0]) begin
            credits <= credits + 1'b1;
          end
        end
        // Both or neither cancel out
        default: begin
          credits <= credits;
        end
      endcase
    end
  end

  // Stall flag for the issue stage
  assign no_credit = (credits == '0);

endmodule : credit_counter

// File: src/request_issue.sv
// Presents one request at a time so throughput is one request per three cycles at best
`timescale 1ns/10ps

module request_issue (
  input  logic                          ap_clk         ,
  input  logic                          control_areset ,
  input  logic                          fifo_empty     ,
  input  logic                          no_credit      ,
  output logic                          rd_en          ,
  input  cache_req_pkg::cache_request_t rd_data        ,
  output cache_req_pkg::cache_request_t cache_req      ,
  input  logic                          cache_req_ready,
  output logic                          take
);

  // ----------------------------------------------------------------------
  // Issue FSM
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    st_wait,
    st_fetch,
    st_hold
  } state_t;

  state_t state;
  state_t state_next;

  // Pop only with data present and a credit free
  assign rd_en = (state == st_wait) & ~fifo_empty & ~no_credit;

  // Cache accepted the held request
  assign take = (state == st_hold) & cache_req.valid & cache_req_ready;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state <= st_wait;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_wait: begin
        if (rd_en) begin
          state_next = st_fetch;
        end
      end
      // FIFO output now valid
      st_fetch: begin
        state_next = rd_data.valid ? st_hold : st_wait;
      end
      st_hold: begin
        if (take) begin
          state_next = st_wait;
        end
      end
      default: begin
        state_next = st_wait;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------

  // Held unchanged until accepted
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      cache_req.valid <= 1'b0;
    end else if (state == st_fetch) begin
      cache_req.valid <= rd_data.valid;
    end else if (take) begin
      cache_req.valid <= 1'b0;
    end
    if (state == st_fetch) begin
      cache_req.req_id <= rd_data.req_id;
      cache_req.addr   <= rd_data.addr;
    end
  end

endmodule : request_issue

// File: src/cache_request_generator.sv
// Read requests only and at most outstanding_max requests wait at the cache for completion
`timescale 1ns/10ps

module cache_request_generator (
  input  logic                                     ap_clk                                    ,
  input  logic                                     control_areset                            ,
  input  cache_req_pkg::mem_request_t              mem_req_in [cache_req_pkg::num_requestors],
  output logic [cache_req_pkg::num_requestors-1:0] mem_req_ready                             ,
  output cache_req_pkg::cache_request_t            cache_req                                 ,
  input  logic                                     cache_req_ready                           ,
  input  logic                                     cache_resp_done                           ,
  output cache_req_pkg::fifo_status_t              fifo_status
);
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Internal paths
  // ----------------------------------------------------------------------
  cache_request_t fifo_wr;
  cache_request_t fifo_rd;
  logic           fifo_rd_en;
  logic           no_credit;
  logic           take;

  // Arbitration and address forming
  request_arbiter arbiter_i (
    .ap_clk          (ap_clk                 ),
    .control_areset  (control_areset         ),
    .mem_req_in      (mem_req_in             ),
    .mem_req_ready   (mem_req_ready          ),
    .fifo_almost_full(fifo_status.almost_full),
    .fifo_wr         (fifo_wr                )
  );

  // Request queue
  // Status goes straight out for monitoring
  request_fifo #(
    .payload_t(cache_request_t)
  ) fifo_i (
    .ap_clk        (ap_clk        ),
    .control_areset(control_areset),
    .wr_data       (fifo_wr       ),
    .rd_en         (fifo_rd_en    ),
    .rd_data       (fifo_rd       ),
    .status        (fifo_status   )
  );

  // Outstanding request credits
  credit_counter credit_i (
    .ap_clk        (ap_clk         ),
    .control_areset(control_areset ),
    .take          (take           ),
    .give          (cache_resp_done),
    .no_credit     (no_credit      )
  );

  // Cache side handshake
  request_issue issue_i (
    .ap_clk         (ap_clk           ),
    .control_areset (control_areset   ),
    .fifo_empty     (fifo_status.empty),
    .no_credit      (no_credit        ),
    .rd_en          (fifo_rd_en       ),
    .rd_data        (fifo_rd          ),
    .cache_req      (cache_req        ),
    .cache_req_ready(cache_req_ready  ),
    .take           (take             )
  );

endmodule : cache_request_generator

// File: bench/cache_request_generator_tb.sv
// Reads bench/cache_request_golden.txt relative to the project root and stops at the first failed check
`timescale 1ns/10ps

module cache_request_generator_tb;
  import cache_req_pkg::*;

  // ----------------------------------------------------------------------
  // Run limits and phases
  // ----------------------------------------------------------------------
  localparam int max_rows        = 64;
  localparam int cycles_per_row  = 200;
  localparam int phase_wait_max  = 200;
  localparam int stall_cycles    = 20;
  localparam int stuck_cycles    = 4;
  localparam int ph_backpressure = 0;
  localparam int ph_withhold     = 1;
  localparam int ph_free         = 2;

  // One golden row
  typedef struct packed {
    logic [addr_w-1:0]   base;
    logic [addr_w-1:0]   offset;
    logic [addr_w-1:0]   expect_addr;
  } golden_row_t;

  // DUT connections
  logic                      ap_clk;
  logic                      control_areset;
  mem_request_t              mem_req_in [num_requestors];
  logic [num_requestors-1:0] mem_req_ready;
  cache_request_t            cache_req;
  logic                      cache_req_ready;
  logic                      cache_resp_done;
  fifo_status_t              fifo_status;

  // Golden rows, split by requestor through index lists
  golden_row_t rows [max_rows];
  int          row_total;
  int          req_rows [num_requestors][max_rows];
  int          req_count [num_requestors];
  int          send_pos [num_requestors];
  int          check_pos [num_requestors];

  // Stimulus and cache model state
  logic                      rows_loaded = 1'b0;
  logic                      stim_on;
  int                        phase;
  logic [num_requestors-1:0] fire_req;
  int                        low_run [num_requestors];
  logic                      bp_seen;
  logic [31:0]               rnd;
  int                        delays [$];
  int                        accepted;
  int                        completed;
  logic                      prev_wait;
  cache_request_t            prev_req;
  int                        last_id;
  int                        id_run;

  cache_request_generator dut_i (
    .ap_clk         (ap_clk         ),
    .control_areset (control_areset ),
    .mem_req_in     (mem_req_in     ),
    .mem_req_ready  (mem_req_ready  ),
    .cache_req      (cache_req      ),
    .cache_req_ready(cache_req_ready),
    .cache_resp_done(cache_resp_done),
    .fifo_status    (fifo_status    )
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
    stop_on_error($sformatf("MISMATCH %s: expected %h actual %h", test, exp, act));
  endtask

  // xorshift32 step
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Rows of four hex columns, other lines skipped
  task automatic load_golden_rows();
    int          fd;
    int          n;
    int          idx;
    string       line;
    logic [31:0] f_id;
    logic [31:0] f_base;
    logic [31:0] f_off;
    logic [31:0] f_exp;
    golden_row_t r;
    fd = $fopen("bench/cache_request_golden.txt", "r");
    assert (fd != 0) else stop_on_error("cannot open bench/cache_request_golden.txt");
    row_total = 0;
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%h %h %h %h", f_id, f_base, f_off, f_exp);
      if (n == 4) begin
        assert (f_id < num_requestors) else stop_on_error("golden row names an unknown requestor");
        assert (row_total < max_rows) else stop_on_error("golden file holds too many rows");
        // Base plus offset, wrapping at 32 bits
        assert (f_exp == f_base + f_off)
          else report_mismatch("golden row address", f_base + f_off, f_exp);
        idx           = int'(f_id);
        r.base        = f_base;
        r.offset      = f_off;
        r.expect_addr = f_exp;
        rows[row_total] = r;
        req_rows[idx][req_count[idx]] = row_total;
        req_count[idx]++;
        row_total++;
      end
    end
    $fclose(fd);
    assert (row_total > 0) else stop_on_error("golden file holds no rows");
  endtask

  // ----------------------------------------------------------------------
  // Clock and watchdog
  // ----------------------------------------------------------------------
  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  // Budget scales with the number of golden rows
  initial begin : watchdog
    wait (rows_loaded);
    repeat (cycles_per_row * row_total) @(posedge ap_clk);
    stop_on_error($sformatf("run did not finish within %0d cycles", cycles_per_row * row_total));
  end

  // ----------------------------------------------------------------------
  // Requestors and cache model, all driven on the falling edge
  // ----------------------------------------------------------------------
  always @(negedge ap_clk) begin : drive_and_check
    int                id;
    int                other;
    logic [addr_w-1:0] exp_addr;
    golden_row_t       head;
    if (stim_on) begin
      for (int i = 0; i < num_requestors; i++) begin
        // Step past a packet taken at the last rising edge
        if (fire_req[i]) begin
          send_pos[i]++;
        end
        if (send_pos[i] < req_count[i]) begin
          head = rows[req_rows[i][send_pos[i]]];
          mem_req_in[i].valid          = 1'b1;
          mem_req_in[i].base_address   = head.base;
          mem_req_in[i].address_offset = head.offset;
        end else begin
          mem_req_in[i].valid = 1'b0;
        end
        // Handshake due at the next rising edge
        fire_req[i] = mem_req_in[i].valid & mem_req_ready[i];
        // Slot stuck while data waits
        if (mem_req_in[i].valid && !mem_req_ready[i]) begin
          low_run[i]++;
        end else begin
          low_run[i] = 0;
        end
        if (low_run[i] >= stuck_cycles) begin
          bp_seen = 1'b1;
          // Queue nearly full but never overflowing
          if (phase == ph_backpressure) begin
            assert (!fifo_status.empty && !fifo_status.full && fifo_status.almost_full)
              else report_mismatch("back-pressure fifo flags", 3'b001, fifo_status);
          end
        end
      end

      rnd = next_random(rnd);
      if (phase == ph_backpressure) begin
        cache_req_ready = 1'b0;
      end else begin
        cache_req_ready = (rnd[1:0] != 2'b00);
      end

      // Waiting request must not move
      if (prev_wait) begin
        assert (cache_req == prev_req) else report_mismatch("held request", prev_req, cache_req);
      end

      // Completions, one pulse per cycle, oldest first
      cache_resp_done = 1'b0;
      foreach (delays[k]) begin
        if (delays[k] > 0) begin
          delays[k]--;
        end
      end
      if (phase != ph_withhold && delays.size() > 0 && delays[0] == 0) begin
        void'(delays.pop_front());
        cache_resp_done = 1'b1;
        completed++;
      end

      // Acceptance at the next rising edge
      if (cache_req.valid && cache_req_ready) begin
        id    = int'(cache_req.req_id);
        other = num_requestors - 1 - id;
        assert (check_pos[id] < req_count[id])
          else stop_on_error($sformatf("extra request arrived from requestor %0d", id));
        head     = rows[req_rows[id][check_pos[id]]];
        exp_addr = head.expect_addr;
        assert (cache_req.addr == exp_addr)
          else report_mismatch($sformatf("address forming req %0d", id), exp_addr, cache_req.addr);
        check_pos[id]++;
        // Same requestor run length
        id_run  = (id == last_id) ? id_run + 1 : 1;
        last_id = id;
        assert (id_run <= 2 || check_pos[other] >= req_count[other])
          else stop_on_error($sformatf("requestor %0d won more than twice in a row", id));
        accepted++;
        delays.push_back(1 + (int'(rnd[7:4]) % 6));
      end
      assert (accepted - completed <= outstanding_max)
        else stop_on_error($sformatf("%0d requests outstanding at the cache",
                                     accepted - completed));

      prev_wait = cache_req.valid & ~cache_req_ready;
      prev_req  = cache_req;
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main_sequence
    int waited;
    int snapshot;
    control_areset  = 1'b1;
    cache_req_ready = 1'b0;
    cache_resp_done = 1'b0;
    for (int i = 0; i < num_requestors; i++) begin
      mem_req_in[i] = '0;
      req_count[i]  = 0;
      send_pos[i]   = 0;
      check_pos[i]  = 0;
      low_run[i]    = 0;
    end
    fire_req  = '0;
    stim_on   = 1'b0;
    phase     = ph_backpressure;
    bp_seen   = 1'b0;
    rnd       = 32'h7c3c_cee3;
    accepted  = 0;
    completed = 0;
    prev_wait = 1'b0;
    prev_req  = '0;
    last_id   = -1;
    id_run    = 0;
    load_golden_rows();
    rows_loaded = 1'b1;

    // Two reset cycles
    repeat (2) @(posedge ap_clk);
    @(negedge ap_clk);
    control_areset = 1'b0;
    assert (!cache_req.valid && fifo_status.empty && mem_req_ready == 2'b11)
      else stop_on_error("outputs not at their reset values");
    @(posedge ap_clk);
    stim_on = 1'b1;

    // Cache never ready, queue fills up
    waited = 0;
    while (!bp_seen && waited < phase_wait_max) begin
      @(posedge ap_clk);
      waited++;
    end
    assert (bp_seen) else stop_on_error("mem_req_ready never went low under back-pressure");

    // Completions withheld
    phase  = ph_withhold;
    waited = 0;
    while (accepted - completed < outstanding_max && waited < phase_wait_max) begin
      @(posedge ap_clk);
      waited++;
    end
    assert (accepted - completed == outstanding_max)
      else stop_on_error("credit limit was never reached");
    snapshot = accepted;
    repeat (stall_cycles) @(posedge ap_clk);
    assert (accepted == snapshot) else stop_on_error("requests issued with no credit left");

    // Completions return and issuing resumes
    phase  = ph_free;
    waited = 0;
    while (accepted == snapshot && waited < phase_wait_max) begin
      @(posedge ap_clk);
      waited++;
    end
    assert (accepted > snapshot) else stop_on_error("issuing did not resume after completions");
    while (accepted < row_total || completed < row_total) begin
      @(posedge ap_clk);
    end
    for (int i = 0; i < num_requestors; i++) begin
      assert (check_pos[i] == req_count[i])
        else stop_on_error($sformatf("requests of requestor %0d missing", i));
    end

    // Drain state
    repeat (4) @(posedge ap_clk);
    @(negedge ap_clk);
    assert (fifo_status.empty) else report_mismatch("drain fifo empty", 1, fifo_status.empty);
    assert (!cache_req.valid) else report_mismatch("drain cache_req valid", 0, cache_req.valid);
    assert (mem_req_ready == 2'b11)
      else report_mismatch("drain mem_req_ready", 2'b11, mem_req_ready);
    $display("test passed");
    $finish;
  end

endmodule : cache_request_generator_tb

// File: bench/cache_request_golden.txt
// Columns in hex: requestor, base_address, address_offset, expected cache address
// Expected address is base plus offset, wrapping at 32 bits
0 10000000 00000040 10000040
1 20000000 00000100 20000100
0 10000000 00000080 10000080
1 20000000 00000200 20000200
0 10001000 000000c0 100010c0
1 20002000 00000300 20002300
0 10001000 00000100 10001100
1 20002000 00000400 20002400
0 1000a000 00000abc 1000aabc
1 2000b000 00000def 2000bdef
0 12345678 00001111 12346789
1 23456789 00002222 234589ab
0 7ffffff0 00000020 80000010
1 fffffff0 00000020 00000010
0 10020000 00000004 10020004
1 20030000 00000008 20030008
0 1a2b3c4d 01010101 1b2c3d4e
1 2b3c4d5e 02020202 2d3e4f60
0 10000100 0000ff00 10010000
1 20000100 0000ff00 20010000
0 3000000c 00000010 3000001c
1 4000000c 00000020 4000002c
0 0fffffff 00000001 10000000
1 1fffffff 00000001 20000000

// File: sources.f
src/cache_req_pkg.sv
src/request_arbiter.sv
src/request_fifo.sv
src/credit_counter.sv
src/request_issue.sv
src/cache_request_generator.sv
bench/cache_request_generator_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cache request generator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module cache_request_generator_tb \
  -o cache_request_generator_sim

# A failing run exits non-zero, so keep its output for the search below
sim_out=$(./obj_dir/cache_request_generator_sim 2>&1) || true
echo "$sim_out"

if grep -qx "test passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
